/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := exu_tb
FILELIST  := tb.f
BUILD     := obj_dir
SIM       := $(BUILD)/V$(TOP)
LOG       := sim.log

SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* logic/exu_alu.sv */
`timescale 1ns/100ps

module exu_alu #(
    parameter int XLEN = exu_pkg::XLEN_DEFAULT
) (
    input  logic [XLEN-1:0]    pc,
    input  logic [XLEN-1:0]    rs1,
    input  logic [XLEN-1:0]    rs2,
    input  logic [XLEN-1:0]    imm,
    input  logic [XLEN-1:0]    csr,
    input  exu_pkg::exu_sel_a_e sel_a,
    input  exu_pkg::exu_sel_b_e sel_b,
    input  logic               word,
    input  exu_pkg::exu_op_e   op,
    output logic [XLEN-1:0]    a,
    output logic [XLEN-1:0]    b,
    output logic [XLEN-1:0]    alu_res
);
    import exu_pkg::*;

    logic [5:0]      shamt;
    logic [31:0]     sra_w;
    logic [XLEN-1:0] sra_d;

    always_comb begin
        if (sel_a == SEL_A_RS1) begin
            a = word ? {{(XLEN-32){1'b0}}, rs1[31:0]} : rs1;
        end else begin
            a = pc;
        end
    end

    always_comb begin
        case (sel_b)
            SEL_B_RS2: b = rs2;
            SEL_B_IMM: b = imm;
            SEL_B_CSR: b = csr;
            default:   b = '0;
        endcase
    end

    assign shamt = b[5:0];
    assign sra_w = $signed(a[31:0]) >>> shamt; // 32-bit arithmetic shift for word ops
    assign sra_d = $signed(a) >>> shamt;

    always_comb begin
        case (op)
            OP_ADD:    alu_res = a + b;
            OP_SUB:    alu_res = a - b;
            OP_PASS_A: alu_res = a;
            OP_PASS_B: alu_res = b;
            OP_XOR:    alu_res = a ^ b;
            OP_OR:     alu_res = a | b;
            OP_AND:    alu_res = a & b;
            OP_SLL:    alu_res = a << shamt;
            OP_SRL:    alu_res = a >> shamt;
            OP_SRA:    alu_res = word ? {{(XLEN-32){1'b0}}, sra_w} : sra_d;
            OP_SLT:    alu_res = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            OP_SLTU:   alu_res = {{(XLEN-1){1'b0}}, a < b};
            OP_EQ:     alu_res = {{(XLEN-1){1'b0}}, a == b};
            OP_GE:     alu_res = {{(XLEN-1){1'b0}}, $signed(a) >= $signed(b)};
            OP_GEU:    alu_res = {{(XLEN-1){1'b0}}, a >= b};
            default:   alu_res = '0; // mul/div come from the iterative units
        endcase
    end

endmodule

/* logic/exu_ctrl.sv */
`timescale 1ns/100ps

module exu_ctrl #(
    parameter int XLEN        = exu_pkg::XLEN_DEFAULT,
    parameter int RES_CREDITS = 2
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             flush,
    input  logic             in_valid,
    input  exu_pkg::exu_op_e op,
    input  logic [XLEN-1:0]  alu_res,
    input  logic [XLEN-1:0]  mul_prod,
    input  logic [XLEN-1:0]  div_result,
    input  logic             mul_done,
    input  logic             div_done,
    input  logic             res_credit,
    output exu_pkg::exu_op_e op_q,
    output logic             mul_start,
    output logic             div_start,
    output logic             div_signed,
    output logic             want_rem,
    output logic             res_valid,
    output logic             issue_credit,
    output logic [XLEN-1:0]  res_data
);
    import exu_pkg::*;

    localparam int CW = $clog2(RES_CREDITS + 1);

    typedef enum logic [1:0] {S_IDLE, S_WAIT_UNIT, S_HOLD} state_e;

    state_e          state;
    logic [CW-1:0]   credits;
    logic [XLEN-1:0] hold_q;
    logic            send;

    // a returning credit can be spent in the same cycle
    assign send = (state == S_HOLD) && !flush && ((credits != '0) || res_credit);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credits <= CW'(RES_CREDITS);
        end else if (res_credit && !send) begin
            credits <= credits + 1'b1;
        end else if (send && !res_credit) begin
            credits <= credits - 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= S_IDLE;
            op_q         <= OP_ADD;
            mul_start    <= 1'b0;
            div_start    <= 1'b0;
            div_signed   <= 1'b0;
            want_rem     <= 1'b0;
            res_valid    <= 1'b0;
            issue_credit <= 1'b0;
        end else begin
            mul_start    <= 1'b0;
            div_start    <= 1'b0;
            issue_credit <= 1'b0;
            res_valid    <= send;
            if (flush) begin
                if (state != S_IDLE || in_valid) issue_credit <= 1'b1; // op discarded
                state <= S_IDLE;
            end else begin
                case (state)
                    S_IDLE: if (in_valid) begin
                        op_q <= op;
                        if (op == OP_MUL) begin
                            mul_start <= 1'b1;
                            state     <= S_WAIT_UNIT;
                        end else if (is_multicycle(op)) begin
                            div_start  <= 1'b1;
                            div_signed <= (op == OP_DIV) || (op == OP_REM);
                            want_rem   <= (op == OP_REM) || (op == OP_REMU);
                            state      <= S_WAIT_UNIT;
                        end else begin
                            state <= S_HOLD;
                        end
                    end
                    S_WAIT_UNIT: if (mul_done || div_done) state <= S_HOLD;
                    default: if (send) begin
                        issue_credit <= 1'b1;
                        state        <= S_IDLE;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_WAIT_UNIT && (mul_done || div_done)) begin
            hold_q <= mul_done ? mul_prod : div_result;
        end
        if (send) begin
            res_data <= is_multicycle(op_q) ? hold_q : alu_res; // alu operands stay latched
        end
    end

endmodule

/* logic/exu_div.sv */
`timescale 1ns/100ps

module exu_div #(
    parameter int XLEN = exu_pkg::XLEN_DEFAULT
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            flush,
    input  logic            start,
    input  logic            is_signed,
    input  logic            want_rem,
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    output logic            done,
    output logic [XLEN-1:0] result
);
    localparam int CW = $clog2(XLEN);

    typedef enum logic [1:0] {D_IDLE, D_RUN, D_FIX} dstate_e;

    dstate_e         state;
    logic [CW-1:0]   cnt;
    logic            neg_a;
    logic            neg_b;
    logic            div_zero;
    logic            overflow;
    logic [XLEN-1:0] abs_a;
    logic [XLEN-1:0] abs_b;
    logic [XLEN-1:0] spec_res;
    logic [XLEN-1:0] quo;
    logic [XLEN-1:0] rem;
    logic [XLEN-1:0] dvs;
    logic            q_neg;
    logic            r_neg;
    logic            rem_sel;
    logic [XLEN:0]   r_sh;
    logic            ge;

    assign neg_a    = is_signed & a[XLEN-1];
    assign neg_b    = is_signed & b[XLEN-1];
    assign abs_a    = neg_a ? -a : a;
    assign abs_b    = neg_b ? -b : b;
    assign div_zero = (b == '0);
    assign overflow = is_signed && (a == {1'b1, {(XLEN-1){1'b0}}}) && (&b);

    // RISC-V results for the two special cases
    always_comb begin
        if (div_zero) spec_res = want_rem ? a : '1;
        else          spec_res = want_rem ? '0 : a;
    end

    assign r_sh = {rem, quo[XLEN-1]};
    assign ge   = (r_sh >= {1'b0, dvs});

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= D_IDLE;
            cnt   <= '0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            if (flush) begin
                state <= D_IDLE;
            end else begin
                case (state)
                    D_IDLE: if (start) begin
                        if (div_zero || overflow) begin
                            done <= 1'b1; // no iterations needed
                        end else begin
                            state <= D_RUN;
                            cnt   <= '0;
                        end
                    end
                    D_RUN: begin
                        cnt <= cnt + 1'b1;
                        if (cnt == CW'(XLEN - 1)) state <= D_FIX;
                    end
                    default: begin
                        state <= D_IDLE;
                        done  <= 1'b1;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            D_IDLE: if (start) begin
                quo     <= abs_a;
                rem     <= '0;
                dvs     <= abs_b;
                q_neg   <= neg_a ^ neg_b;
                r_neg   <= neg_a; // remainder follows dividend
                rem_sel <= want_rem;
                result  <= spec_res;
            end
            D_RUN: begin
                rem <= ge ? XLEN'(r_sh - {1'b0, dvs}) : r_sh[XLEN-1:0];
                quo <= {quo[XLEN-2:0], ge};
            end
            default: begin
                result <= rem_sel ? (r_neg ? -rem : rem) : (q_neg ? -quo : quo);
            end
        endcase
    end

endmodule

/* logic/exu_mul.sv */
`timescale 1ns/100ps

module exu_mul #(
    parameter int XLEN = exu_pkg::XLEN_DEFAULT
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            flush,
    input  logic            start,
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    output logic            done,
    output logic [XLEN-1:0] prod
);
    localparam int STEPS = XLEN / 2;
    localparam int CW    = $clog2(STEPS);

    logic            busy;
    logic [CW-1:0]   cnt;
    logic            last;
    logic [XLEN-1:0] mcand;
    logic [XLEN-1:0] mplier;
    logic [XLEN-1:0] acc;
    logic [XLEN-1:0] partial;

    assign last = (cnt == CW'(STEPS - 1));

    // two multiplier bits per step
    always_comb begin
        partial = '0;
        if (mplier[0]) partial = partial + mcand;
        if (mplier[1]) partial = partial + {mcand[XLEN-2:0], 1'b0};
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            cnt  <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (flush) begin
                busy <= 1'b0;
            end else if (start) begin
                busy <= 1'b1;
                cnt  <= '0;
            end else if (busy) begin
                cnt <= cnt + 1'b1;
                if (last) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            mcand  <= a;
            mplier <= b;
            acc    <= '0;
        end else if (busy) begin
            acc    <= acc + partial;
            mcand  <= mcand << 2;
            mplier <= mplier >> 2;
        end
    end

    assign prod = acc; // stable once busy drops

endmodule

/* logic/exu_pkg.sv */
package exu_pkg;

    localparam int XLEN_DEFAULT = 64;

    typedef enum logic [4:0] {
        OP_ADD    = 5'd0,
        OP_SUB    = 5'd1,
        OP_PASS_A = 5'd2,
        OP_PASS_B = 5'd3,
        OP_XOR    = 5'd4,
        OP_OR     = 5'd5,
        OP_AND    = 5'd6,
        OP_SLL    = 5'd7,
        OP_SRL    = 5'd8,
        OP_SRA    = 5'd9,
        OP_SLT    = 5'd10,
        OP_SLTU   = 5'd11,
        OP_EQ     = 5'd12,
        OP_GE     = 5'd13,
        OP_GEU    = 5'd14,
        OP_MUL    = 5'd15, // low half of product only
        OP_DIV    = 5'd16,
        OP_DIVU   = 5'd17,
        OP_REM    = 5'd18,
        OP_REMU   = 5'd19
    } exu_op_e;

    // operand a source
    typedef enum logic {
        SEL_A_PC  = 1'b0,
        SEL_A_RS1 = 1'b1
    } exu_sel_a_e;

    // operand b source, 2'b11 unused
    typedef enum logic [1:0] {
        SEL_B_RS2 = 2'd0,
        SEL_B_IMM = 2'd1,
        SEL_B_CSR = 2'd2
    } exu_sel_b_e;

    // ops handled by the iterative units
    function automatic logic is_multicycle(exu_op_e op);
        return op inside {OP_MUL, OP_DIV, OP_DIVU, OP_REM, OP_REMU};
    endfunction

endpackage

/* logic/exu_top.sv */
`timescale 1ns/100ps

module exu_top #(
    parameter int XLEN        = exu_pkg::XLEN_DEFAULT,
    parameter int RES_CREDITS = 2
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                flush,
    input  logic                in_valid,
    input  exu_pkg::exu_op_e    op,
    input  logic [XLEN-1:0]     pc,
    input  logic [XLEN-1:0]     rs1,
    input  logic [XLEN-1:0]     rs2,
    input  logic [XLEN-1:0]     imm,
    input  logic [XLEN-1:0]     csr,
    input  exu_pkg::exu_sel_a_e sel_a,
    input  exu_pkg::exu_sel_b_e sel_b,
    input  logic                word,
    input  logic                res_credit,
    output logic                issue_credit,
    output logic                res_valid,
    output logic [XLEN-1:0]     res_data
);
    import exu_pkg::*;

    logic [XLEN-1:0] pc_q, rs1_q, rs2_q, imm_q, csr_q;
    exu_sel_a_e      sel_a_q;
    exu_sel_b_e      sel_b_q;
    logic            word_q;
    exu_op_e         op_q;
    logic [XLEN-1:0] a, b, alu_res, mul_prod, div_result;
    logic            mul_start, mul_done, div_start, div_done, div_signed, want_rem;

    // operands held until the next issue
    always_ff @(posedge clk) begin
        if (in_valid) begin
            pc_q    <= pc;
            rs1_q   <= rs1;
            rs2_q   <= rs2;
            imm_q   <= imm;
            csr_q   <= csr;
            sel_a_q <= sel_a;
            sel_b_q <= sel_b;
            word_q  <= word;
        end
    end

    exu_ctrl #(.XLEN(XLEN), .RES_CREDITS(RES_CREDITS)) u_ctrl (
        .clk(clk), .rst_n(rst_n), .flush(flush), .in_valid(in_valid), .op(op),
        .alu_res(alu_res), .mul_prod(mul_prod), .div_result(div_result),
        .mul_done(mul_done), .div_done(div_done), .res_credit(res_credit),
        .op_q(op_q), .mul_start(mul_start), .div_start(div_start),
        .div_signed(div_signed), .want_rem(want_rem), .res_valid(res_valid),
        .issue_credit(issue_credit), .res_data(res_data)
    );

    exu_alu #(.XLEN(XLEN)) u_alu (
        .pc(pc_q), .rs1(rs1_q), .rs2(rs2_q), .imm(imm_q), .csr(csr_q),
        .sel_a(sel_a_q), .sel_b(sel_b_q), .word(word_q), .op(op_q),
        .a(a), .b(b), .alu_res(alu_res)
    );

    exu_mul #(.XLEN(XLEN)) u_mul (
        .clk(clk), .rst_n(rst_n), .flush(flush), .start(mul_start),
        .a(a), .b(b), .done(mul_done), .prod(mul_prod)
    );

    exu_div #(.XLEN(XLEN)) u_div (
        .clk(clk), .rst_n(rst_n), .flush(flush), .start(div_start),
        .is_signed(div_signed), .want_rem(want_rem), .a(a), .b(b),
        .done(div_done), .result(div_result)
    );

endmodule

/* sim/exu_properties.sv */
`timescale 1ns/100ps

module exu_properties #(
    parameter int RES_CREDITS = 2,
    parameter int CW          = 2
) (
    input logic          clk,
    input logic          rst_n,
    input logic          in_valid,
    input logic          res_credit,
    input logic [CW-1:0] credits,
    input logic          res_valid,
    input logic          issue_credit
);

    int   in_flight; // results sent and not yet freed by writeback
    logic held;      // op accepted, credit not yet back

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_flight <= 0;
            held      <= 1'b0;
        end else begin
            in_flight <= in_flight + int'(res_valid) - int'(res_credit);
            if (in_valid) begin
                held <= 1'b1;
            end else if (issue_credit) begin
                held <= 1'b0;
            end
        end
    end

    res_valid_needs_credit: assert property (@(posedge clk) disable iff (!rst_n)
        res_valid |-> in_flight < RES_CREDITS)
        else $error("res_valid rose with no result credit");

    credits_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        credits <= CW'(RES_CREDITS))
        else $error("result credit count above %0d", RES_CREDITS);

    issue_credit_after_hold: assert property (@(posedge clk) disable iff (!rst_n)
        issue_credit |-> held)
        else $error("issue_credit pulsed with no operation held");

endmodule

bind exu_ctrl exu_properties #(.RES_CREDITS(RES_CREDITS), .CW(CW)) u_props (
    .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .res_credit(res_credit),
    .credits(credits), .res_valid(res_valid), .issue_credit(issue_credit)
);

/* sim/exu_tb.sv */
`timescale 1ns/100ps

module exu_tb;
    import exu_pkg::*;

    localparam int XLEN    = 64;
    localparam int N_ALU   = 180; // 15 ops x 12 select/word combinations
    localparam int N_MUL   = 16;
    localparam int N_DIV   = 88;
    localparam int TIMEOUT = 2 * (N_ALU * 8 + N_MUL * 45 + N_DIV * 80 + 500);
    localparam logic [XLEN-1:0] MOST_NEG = {1'b1, {(XLEN-1){1'b0}}};

    logic            clk = 1'b0;
    logic            rst_n;
    logic            flush;
    logic            in_valid;
    exu_op_e         op;
    logic [XLEN-1:0] pc, rs1, rs2, imm, csr;
    exu_sel_a_e      sel_a;
    exu_sel_b_e      sel_b;
    logic            word;
    logic            res_credit;
    logic            issue_credit;
    logic            res_valid;
    logic [XLEN-1:0] res_data;

    logic [31:0]     rng = 32'hffd4_a399;
    int              cyc = 0;
    int              issued = 0;
    int              credits_back = 0;
    int              issue_cyc = 0;
    logic [XLEN-1:0] res_q[$];
    int              res_cyc_q[$];
    int              errors = 0;
    int              checks = 0;

    exu_top #(.XLEN(XLEN), .RES_CREDITS(2)) UUT (
        .clk(clk), .rst_n(rst_n), .flush(flush), .in_valid(in_valid), .op(op),
        .pc(pc), .rs1(rs1), .rs2(rs2), .imm(imm), .csr(csr),
        .sel_a(sel_a), .sel_b(sel_b), .word(word), .res_credit(res_credit),
        .issue_credit(issue_credit), .res_valid(res_valid), .res_data(res_data)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= TIMEOUT) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT);
            $display("TESTS FAILED");
            $finish;
        end
    end

    // outputs sampled mid-cycle
    always @(negedge clk) begin
        if (rst_n) begin
            if (issue_credit) credits_back++;
            if (in_valid) issue_cyc = cyc + 1; // edge that captures it
            if (res_valid) begin
                res_q.push_back(res_data);
                res_cyc_q.push_back(cyc);
            end
        end
    end

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng = x;
        return x;
    endfunction

    // random values with corner cases mixed in
    function automatic logic [XLEN-1:0] pick_operand();
        logic [31:0] sel;
        logic [31:0] hi;
        logic [31:0] lo;
        sel = next_rand();
        hi  = next_rand();
        lo  = next_rand();
        case (sel[2:0])
            3'd0:    return '0;
            3'd1:    return '1;
            3'd2:    return MOST_NEG;
            3'd3:    return 64'd1;
            3'd4:    return {32'h0, lo};
            default: return {hi, lo};
        endcase
    endfunction

    function automatic logic [XLEN-1:0] expected_result(exu_op_e o, logic [XLEN-1:0] x,
                                                        logic [XLEN-1:0] y, logic w);
        logic [5:0]      sh;
        logic [XLEN-1:0] t;
        sh = y[5:0];
        case (o)
            OP_ADD:    return x + y;
            OP_SUB:    return x - y;
            OP_PASS_A: return x;
            OP_PASS_B: return y;
            OP_XOR:    return x ^ y;
            OP_OR:     return x | y;
            OP_AND:    return x & y;
            OP_SLL:    return x << sh;
            OP_SRL:    return x >> sh;
            OP_SRA: begin
                t = w ? {{32{x[31]}}, x[31:0]} : x; // word form shifts the low half
                t = $signed(t) >>> sh;
                return w ? {32'h0, t[31:0]} : t;
            end
            OP_SLT:    return ($signed(x) < $signed(y)) ? 64'd1 : 64'd0;
            OP_SLTU:   return (x < y) ? 64'd1 : 64'd0;
            OP_EQ:     return (x == y) ? 64'd1 : 64'd0;
            OP_GE:     return ($signed(x) >= $signed(y)) ? 64'd1 : 64'd0;
            OP_GEU:    return (x >= y) ? 64'd1 : 64'd0;
            OP_MUL:    return x * y;
            OP_DIVU:   return (y == '0) ? '1 : x / y;
            OP_REMU:   return (y == '0) ? x : x % y;
            OP_DIV: begin
                if (y == '0) return '1;
                if (x == MOST_NEG && y == '1) return x;
                return $signed(x) / $signed(y);
            end
            OP_REM: begin
                if (y == '0) return x;
                if (x == MOST_NEG && y == '1) return '0;
                return $signed(x) % $signed(y);
            end
            default:   return '0;
        endcase
    endfunction

    task automatic issue(exu_op_e o, exu_sel_a_e sa, exu_sel_b_e sb, logic w,
                         logic [XLEN-1:0] p, r1, r2, im, cs);
        @(posedge clk);
        while (1 + credits_back - issued <= 0) @(posedge clk); // hold the single credit
        issued++;
        in_valid <= 1'b1;
        op       <= o;
        sel_a    <= sa;
        sel_b    <= sb;
        word     <= w;
        pc       <= p;
        rs1      <= r1;
        rs2      <= r2;
        imm      <= im;
        csr      <= cs;
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    task automatic wait_result(output logic [XLEN-1:0] data, output int lat);
        while (res_q.size() == 0) @(posedge clk);
        data = res_q.pop_front();
        lat  = res_cyc_q.pop_front() - issue_cyc;
    endtask

    task automatic give_res_credit();
        @(posedge clk);
        res_credit <= 1'b1;
        @(posedge clk);
        res_credit <= 1'b0;
    endtask

    task automatic check_data(string what, logic [XLEN-1:0] want, logic [XLEN-1:0] got);
        checks++;
        if (got !== want) begin
            errors++;
            $display("error res_data (%s): expected %h, got %h", what, want, got);
        end
    endtask

    task automatic run_op(exu_op_e o, exu_sel_a_e sa, exu_sel_b_e sb, logic w,
                          logic [XLEN-1:0] r1, r2);
        logic [XLEN-1:0] p, im, cs, x, y, got;
        int              lat;
        p  = pick_operand();
        im = pick_operand();
        cs = pick_operand();
        x  = (sa == SEL_A_PC) ? p : (w ? {32'h0, r1[31:0]} : r1);
        y  = (sb == SEL_B_RS2) ? r2 : ((sb == SEL_B_IMM) ? im : cs);
        issue(o, sa, sb, w, p, r1, r2, im, cs);
        wait_result(got, lat);
        check_data(o.name(), expected_result(o, x, y, w), got);
        if (!is_multicycle(o) && lat != 1) begin
            errors++;
            $display("%s result arrived %0d cycles after issue instead of 1", o.name(), lat);
        end
        give_res_credit();
    endtask

    task automatic single_cycle_ops();
        int      e0;
        exu_op_e o;
        e0 = errors;
        for (int i = 0; i < 20; i++) begin
            o = exu_op_e'(i);
            if (is_multicycle(o)) continue;
            // s[0] picks operand a, s[1] the word flag, s/4 operand b
            for (int s = 0; s < 12; s++) begin
                run_op(o, exu_sel_a_e'(s[0]), exu_sel_b_e'(s / 4), s[1],
                       pick_operand(), pick_operand());
            end
        end
        $display("single-cycle ops done, %0d errors", errors - e0);
    endtask

    task automatic mul_ops();
        int              e0;
        logic [XLEN-1:0] x, y;
        e0 = errors;
        for (int i = 0; i < N_MUL; i++) begin
            x = pick_operand();
            y = (i == 0) ? '0 : pick_operand();
            if (i == 1) begin
                x = '1;
                y = '1;
            end
            run_op(OP_MUL, SEL_A_RS1, SEL_B_RS2, 1'b0, x, y);
        end
        $display("mul done, %0d errors", errors - e0);
    endtask

    task automatic div_ops();
        int              e0;
        logic [XLEN-1:0] x, y;
        e0 = errors;
        for (int i = 0; i < N_DIV; i++) begin
            x = pick_operand();
            y = pick_operand();
            if (i % 22 == 0) y = '0;
            if (i % 22 == 1) begin
                x = MOST_NEG;
                y = '1;
            end
            run_op(exu_op_e'(16 + i / 22), SEL_A_RS1, SEL_B_RS2, 1'b0, x, y);
        end
        $display("div/rem done, %0d errors", errors - e0);
    endtask

    task automatic backpressure();
        int              e0;
        int              lat;
        logic [XLEN-1:0] v[4];
        logic [XLEN-1:0] got;
        e0 = errors;
        foreach (v[i]) v[i] = pick_operand();
        // writeback keeps its slots full
        for (int i = 0; i < 3; i++) issue(OP_PASS_A, SEL_A_RS1, SEL_B_RS2, 1'b0, '0, v[i], '0, '0, '0);
        repeat (20) @(posedge clk);
        if (res_q.size() != 2) begin
            errors++;
            $display("back-pressure: %0d results without credit, expected 2", res_q.size());
        end
        if (issued - credits_back != 1) begin
            errors++;
            $display("back-pressure: issue credit came back while a result was held");
        end
        for (int i = 0; i < 2; i++) begin
            wait_result(got, lat);
            check_data("held result", v[i], got);
        end
        give_res_credit();
        wait_result(got, lat);
        check_data("held result", v[2], got);
        issue(OP_PASS_A, SEL_A_RS1, SEL_B_RS2, 1'b0, '0, v[3], '0, '0, '0);
        repeat (5) @(posedge clk);
        if (res_q.size() != 0) begin
            errors++;
            $display("back-pressure: result sent with no credit left");
        end
        give_res_credit();
        wait_result(got, lat);
        check_data("held result", v[3], got);
        give_res_credit();
        give_res_credit();
        $display("back-pressure done, %0d errors", errors - e0);
    endtask

    task automatic flush_div();
        int e0;
        e0 = errors;
        issue(OP_DIV, SEL_A_RS1, SEL_B_RS2, 1'b0, '0, pick_operand(), 64'd7, '0, '0);
        repeat (10) @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        repeat (80) @(posedge clk);
        if (res_q.size() != 0) begin
            errors++;
            $display("flush: the flushed div still produced a result");
        end
        if (credits_back != issued) begin
            errors++;
            $display("flush: issue credit was not returned");
        end
        run_op(OP_DIV, SEL_A_RS1, SEL_B_RS2, 1'b0, pick_operand(), pick_operand());
        run_op(OP_ADD, SEL_A_RS1, SEL_B_IMM, 1'b0, pick_operand(), pick_operand());
        $display("flush done, %0d errors", errors - e0);
    endtask

    initial begin
        rst_n      <= 1'b0;
        flush      <= 1'b0;
        in_valid   <= 1'b0;
        op         <= OP_ADD;
        pc         <= '0;
        rs1        <= '0;
        rs2        <= '0;
        imm        <= '0;
        csr        <= '0;
        sel_a      <= SEL_A_RS1;
        sel_b      <= SEL_B_RS2;
        word       <= 1'b0;
        res_credit <= 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        if (res_valid || issue_credit) begin
            errors++;
            $display("reset: res_valid or issue_credit high after reset");
        end
        single_cycle_ops();
        mul_ops();
        div_ops();
        backpressure();
        flush_div();
        $display("5 tests, %0d result checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* tb.f */
logic/exu_pkg.sv
logic/exu_alu.sv
logic/exu_mul.sv
logic/exu_div.sv
logic/exu_ctrl.sv
logic/exu_top.sv
sim/exu_properties.sv
sim/exu_tb.sv
